// ==== adaptive_route_monitor.f ====
rtl/noc_geometry_pkg.sv
rtl/congestion_pkg.sv
rtl/cong_snapshot_stage.sv
rtl/cong_normalizer.sv
rtl/cong_level_stage.sv
rtl/port_presel_stage.sv
rtl/deadlock_watchdog.sv
rtl/adaptive_route_monitor.sv
tb/tb_clock_gen.sv
tb/adaptive_route_monitor_tb.sv

// ==== rtl/adaptive_route_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module adaptive_route_monitor
    import noc_geometry_pkg::*;
    import congestion_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire pv_vec_t ivc_request_all,
    input  wire pv_vec_t ivc_granted_all,
    input  wire pv_vec_t ovc_available_all,
    input  wire cong_all_t congestion_in_all,
    output cong_all_t congestion_out_all,
    output presel_t port_pre_sel,
    output logic deadlock_detect
);

    dir_vc_t busy_vcs;     // snapshot to level stage
    dir_vc_t stalled_vcs;

    // congestion report, two cycles from inputs
    cong_snapshot_stage u_snapshot (
        .clk               (clk),
        .arst_n            (arst_n),
        .ovc_available_all (ovc_available_all),
        .ivc_request_all   (ivc_request_all),
        .ivc_granted_all   (ivc_granted_all),
        .busy_vcs          (busy_vcs),
        .stalled_vcs       (stalled_vcs)
    );

    cong_level_stage u_level (
        .clk                (clk),
        .arst_n             (arst_n),
        .busy_vcs           (busy_vcs),
        .stalled_vcs        (stalled_vcs),
        .congestion_out_all (congestion_out_all)
    );

    // neighbour levels into x/y preference
    port_presel_stage u_presel (
        .clk               (clk),
        .arst_n            (arst_n),
        .congestion_in_all (congestion_in_all),
        .port_pre_sel      (port_pre_sel)
    );

    deadlock_watchdog u_watchdog (
        .clk             (clk),
        .arst_n          (arst_n),
        .ivc_request_all (ivc_request_all),
        .ivc_granted_all (ivc_granted_all),
        .deadlock_detect (deadlock_detect)
    );

endmodule

`default_nettype wire

// ==== rtl/cong_level_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module cong_level_stage
    import noc_geometry_pkg::*;
    import congestion_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire dir_vc_t busy_vcs,
    input  wire dir_vc_t stalled_vcs,
    output cong_all_t congestion_out_all
);

    function automatic load_t count_vcs(input vc_mask_t mask);
        load_t cnt;
        cnt = '0;
        for (int v = 0; v < NUM_VCS; v++) begin
            cnt = cnt + load_t'(mask[v]);
        end
        return cnt;
    endfunction

    load_t     busy_cnt  [NUM_DIRS];
    load_t     stall_cnt [NUM_DIRS];
    load_t     load      [NUM_DIRS];
    load_t     busy_total;
    cong_dir_t level;
    cong_all_t report_next;

    always_comb begin
        busy_total = '0;
        for (int d = 0; d < NUM_DIRS; d++) begin
            busy_cnt[d]  = count_vcs(busy_vcs[d]);
            stall_cnt[d] = count_vcs(stalled_vcs[d]);
            busy_total   = busy_total + busy_cnt[d];
        end
        // busy OVCs of the other three directions + 3x own stalled IVCs
        for (int d = 0; d < NUM_DIRS; d++) begin
            load[d] = (busy_total - busy_cnt[d]) + stall_cnt[d] + (stall_cnt[d] << 1);
        end
    end

    for (genvar d = 0; d < NUM_DIRS; d++) begin : g_norm
        cong_normalizer u_norm (
            .load  (load[d]),
            .level (level[d])
        );
    end

    always_comb begin
        report_next[PORT_LOCAL * CONG_W +: CONG_W] = '0;  // nothing reported for local
        for (int d = 0; d < NUM_DIRS; d++) begin
            report_next[(PORT_EAST + d) * CONG_W +: CONG_W] = level[d];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            congestion_out_all <= '0;
        end else begin
            congestion_out_all <= report_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cong_normalizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cong_normalizer
    import congestion_pkg::*;
(
    input  wire load_t load,
    output cong_level_t level
);

    logic [2**CONG_W-1:0] band;  // one-hot, one bit per congestion level

    // band i covers LOAD_MAX*i/8 < load <= LOAD_MAX*(i+1)/8
    for (genvar i = 0; i < 2**CONG_W; i++) begin : g_band
        if (i == 0) begin : g_first
            assign band[i] = (load <= load_t'(LOAD_MAX / (2**CONG_W)));
        end else if (i == 2**CONG_W - 1) begin : g_last
            assign band[i] = (load > load_t'((LOAD_MAX * i) / (2**CONG_W)));  // open top
        end else begin : g_mid
            assign band[i] = (load > load_t'((LOAD_MAX * i) / (2**CONG_W))) &&
                             (load <= load_t'((LOAD_MAX * (i + 1)) / (2**CONG_W)));
        end
    end

    // one-hot to binary
    always_comb begin
        level = '0;
        for (int i = 0; i < 2**CONG_W; i++) begin
            if (band[i]) begin
                level = level | cong_level_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cong_snapshot_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module cong_snapshot_stage
    import noc_geometry_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire pv_vec_t ovc_available_all,
    input  wire pv_vec_t ivc_request_all,
    input  wire pv_vec_t ivc_granted_all,
    output dir_vc_t busy_vcs,
    output dir_vc_t stalled_vcs
);

    pv_vec_t stalled_all;
    dir_vc_t busy_next;
    dir_vc_t stalled_next;

    assign stalled_all = ivc_request_all & ~ivc_granted_all;  // asking but lost arbitration

    // split per direction, local port dropped
    always_comb begin
        for (int d = 0; d < NUM_DIRS; d++) begin
            busy_next[d]    = ~ovc_available_all[(PORT_EAST + d) * NUM_VCS +: NUM_VCS];
            stalled_next[d] = stalled_all[(PORT_EAST + d) * NUM_VCS +: NUM_VCS];
        end
    end

    // both masks captured on the same edge so the level stage sees one sample
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_vcs    <= '0;
            stalled_vcs <= '0;
        end else begin
            busy_vcs    <= busy_next;
            stalled_vcs <= stalled_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/congestion_pkg.sv ====
`default_nettype none

package congestion_pkg;

    import noc_geometry_pkg::*;

    localparam int CONG_W = 3;

    typedef logic [CONG_W-1:0]           cong_level_t;  // 0 least congested, 7 most
    typedef logic [NUM_PORTS*CONG_W-1:0] cong_all_t;    // local field always zero
    typedef cong_level_t [NUM_DIRS-1:0]  cong_dir_t;

    // busy OVCs of three ports plus 3x stalled IVCs of one port
    localparam int LOAD_MAX = 6 * NUM_VCS;
    localparam int LOAD_W   = $clog2(LOAD_MAX + 1);

    typedef logic [LOAD_W-1:0] load_t;

    // quadrant bits of the pre-select vector
    localparam int Q0 = 0;                        // west / south
    localparam int Q1 = 1;                        // west / north
    localparam int Q2 = 2;                        // east / south
    localparam int Q3 = 3;                        // east / north

    typedef logic [NUM_DIRS-1:0] presel_t;        // 0 go x, 1 go y

    localparam int STALL_LIMIT = 16;

    typedef logic [$clog2(STALL_LIMIT)-1:0] stall_cnt_t;

endpackage

`default_nettype wire

// ==== rtl/deadlock_watchdog.sv ====
`timescale 1ns/1ps
`default_nettype none

module deadlock_watchdog
    import noc_geometry_pkg::*;
    import congestion_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire pv_vec_t ivc_request_all,
    input  wire pv_vec_t ivc_granted_all,
    output logic deadlock_detect
);

    pv_vec_t                   grant_q;   // grants seen one cycle ago
    vc_mask_t                  vc_clear;
    vc_mask_t                  vc_count;
    vc_mask_t                  vc_hit;
    stall_cnt_t [NUM_VCS-1:0]  stall_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant_q <= '0;
        end else begin
            grant_q <= ivc_granted_all;
        end
    end

    // same VC number merged over all ports
    always_comb begin
        vc_clear = '0;
        vc_count = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                vc_clear[v] = vc_clear[v] | grant_q[p * NUM_VCS + v];
                vc_count[v] = vc_count[v] | ivc_request_all[p * NUM_VCS + v];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stall_cnt <= '0;
        end else begin
            for (int v = 0; v < NUM_VCS; v++) begin
                if (vc_clear[v]) begin
                    stall_cnt[v] <= '0;
                end else if (vc_count[v]) begin
                    stall_cnt[v] <= stall_cnt[v] + 1'b1;  // wraps past 15
                end
            end
        end
    end

    always_comb begin
        for (int v = 0; v < NUM_VCS; v++) begin
            vc_hit[v] = (stall_cnt[v] == stall_cnt_t'(STALL_LIMIT - 1));
        end
    end

    assign deadlock_detect = |vc_hit;

endmodule

`default_nettype wire

// ==== rtl/noc_geometry_pkg.sv ====
`default_nettype none

package noc_geometry_pkg;

    localparam int NUM_PORTS = 5;
    localparam int NUM_VCS   = 4;
    localparam int NUM_DIRS  = NUM_PORTS - 1;     // every port except local
    localparam int PV        = NUM_PORTS * NUM_VCS;

    // field positions inside any router-wide vector
    localparam int PORT_LOCAL = 0;
    localparam int PORT_EAST  = 1;
    localparam int PORT_NORTH = 2;
    localparam int PORT_WEST  = 3;
    localparam int PORT_SOUTH = 4;

    typedef logic [NUM_VCS-1:0] vc_mask_t;        // one bit per VC of a port
    typedef logic [PV-1:0]      pv_vec_t;         // port p holds bits p*4 .. p*4+3

    // direction index 0..3 is east, north, west, south
    typedef vc_mask_t [NUM_DIRS-1:0] dir_vc_t;

endpackage

`default_nettype wire

// ==== rtl/port_presel_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_presel_stage
    import noc_geometry_pkg::*;
    import congestion_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire cong_all_t congestion_in_all,
    output presel_t port_pre_sel
);

    cong_level_t east_lvl;
    cong_level_t north_lvl;
    cong_level_t west_lvl;
    cong_level_t south_lvl;
    presel_t     presel_next;

    // local field of the incoming vector is not looked at
    assign east_lvl  = congestion_in_all[PORT_EAST  * CONG_W +: CONG_W];
    assign north_lvl = congestion_in_all[PORT_NORTH * CONG_W +: CONG_W];
    assign west_lvl  = congestion_in_all[PORT_WEST  * CONG_W +: CONG_W];
    assign south_lvl = congestion_in_all[PORT_SOUTH * CONG_W +: CONG_W];

    //  Q1 | Q3
    //  ---+---   a tie keeps x
    //  Q0 | Q2
    assign presel_next[Q3] = (east_lvl > north_lvl);
    assign presel_next[Q1] = (west_lvl > north_lvl);
    assign presel_next[Q2] = (east_lvl > south_lvl);
    assign presel_next[Q0] = (west_lvl > south_lvl);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            port_pre_sel <= '0;
        end else begin
            port_pre_sel <= presel_next;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module adaptive_route_monitor_tb \
    -f adaptive_route_monitor.f

output=$(./obj_dir/Vadaptive_route_monitor_tb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qxF '>>> PASS'; then
    exit 0
else
    exit 1
fi

// ==== tb/adaptive_route_monitor_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module adaptive_route_monitor_tb
    import noc_geometry_pkg::*;
    import congestion_pkg::*;
();

    localparam int      NUM_ROWS    = 8;
    localparam int      NUM_RANDOM  = 40;
    localparam int      HOLD_CYCLES = 3;
    localparam pv_vec_t EAST_VC2    = pv_vec_t'(1) << (PORT_EAST * NUM_VCS + 2);

    typedef struct packed {
        pv_vec_t   req;
        pv_vec_t   gnt;
        pv_vec_t   avail;
        cong_all_t cin;
        cong_all_t exp_cong;
        presel_t   exp_presel;
    } row_t;

    logic      clk;
    logic      arst_n;
    pv_vec_t   ivc_request_all;
    pv_vec_t   ivc_granted_all;
    pv_vec_t   ovc_available_all;
    cong_all_t congestion_in_all;
    cong_all_t congestion_out_all;
    presel_t   port_pre_sel;
    logic      deadlock_detect;

    row_t        rows [NUM_ROWS];
    logic [31:0] rng_state;
    int          cong_errors;
    int          presel_errors;
    int          detect_errors;
    int          timeout_errors;

    tb_clock_gen u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    adaptive_route_monitor UUT (
        .clk                (clk),
        .arst_n             (arst_n),
        .ivc_request_all    (ivc_request_all),
        .ivc_granted_all    (ivc_granted_all),
        .ovc_available_all  (ovc_available_all),
        .congestion_in_all  (congestion_in_all),
        .congestion_out_all (congestion_out_all),
        .port_pre_sel       (port_pre_sel),
        .deadlock_detect    (deadlock_detect)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int ones_in(input vc_mask_t mask);
        int n;
        n = 0;
        for (int v = 0; v < NUM_VCS; v++) begin
            if (mask[v]) n++;
        end
        return n;
    endfunction

    // ceil(load / 3) - 1, never below zero
    function automatic cong_level_t load_to_level(input int load);
        if (load <= 3) return '0;
        return cong_level_t'((load + 2) / 3 - 1);
    endfunction

    function automatic cong_all_t congestion_rule(input pv_vec_t req, input pv_vec_t gnt,
                                                  input pv_vec_t avail);
        int        busy  [NUM_DIRS];
        int        stall [NUM_DIRS];
        int        load;
        pv_vec_t   stalled;
        vc_mask_t  busy_mask;
        cong_all_t result;
        stalled = req & ~gnt;
        for (int d = 0; d < NUM_DIRS; d++) begin
            busy_mask = ~avail[(PORT_EAST + d) * NUM_VCS +: NUM_VCS];
            busy[d]   = ones_in(busy_mask);
            stall[d]  = ones_in(stalled[(PORT_EAST + d) * NUM_VCS +: NUM_VCS]);
        end
        result = '0;  // local field stays zero
        for (int d = 0; d < NUM_DIRS; d++) begin
            load = 3 * stall[d];
            for (int o = 0; o < NUM_DIRS; o++) begin
                if (o != d) load += busy[o];
            end
            result[(PORT_EAST + d) * CONG_W +: CONG_W] = load_to_level(load);
        end
        return result;
    endfunction

    function automatic presel_t preselect_rule(input cong_all_t cin);
        cong_level_t e;
        cong_level_t n;
        cong_level_t w;
        cong_level_t s;
        presel_t     result;
        e = cin[PORT_EAST  * CONG_W +: CONG_W];
        n = cin[PORT_NORTH * CONG_W +: CONG_W];
        w = cin[PORT_WEST  * CONG_W +: CONG_W];
        s = cin[PORT_SOUTH * CONG_W +: CONG_W];
        result[Q3] = (e > n);
        result[Q1] = (w > n);
        result[Q2] = (e > s);
        result[Q0] = (w > s);
        return result;
    endfunction

    task automatic check_cong(input cong_all_t got, input cong_all_t exp, input string tag);
        if (got !== exp) begin
            cong_errors++;
            $display("ERROR congestion_out_all %s: got %h expected %h", tag, got, exp);
        end
    endtask

    task automatic check_presel(input presel_t got, input presel_t exp, input string tag);
        if (got !== exp) begin
            presel_errors++;
            $display("ERROR port_pre_sel %s: got %h expected %h", tag, got, exp);
        end
    endtask

    task automatic check_detect(input logic got, input logic exp, input string tag);
        if (got !== exp) begin
            detect_errors++;
            $display("ERROR deadlock_detect %s: got %h expected %h", tag, got, exp);
        end
    endtask

    task automatic drive_inputs(input pv_vec_t req, input pv_vec_t gnt, input pv_vec_t avail,
                                input cong_all_t cin);
        @(posedge clk);
        ivc_request_all   <= req;
        ivc_granted_all   <= gnt;
        ovc_available_all <= avail;
        congestion_in_all <= cin;
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    // polls on falling edges so the flag is read between updates
    task automatic wait_detect(input logic level, input int limit, input string tag);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (deadlock_detect !== level && cycles < limit);
        if (deadlock_detect !== level) begin
            timeout_errors++;
            $display("timeout: deadlock_detect never became %0b within %0d cycles (%s)",
                     level, limit, tag);
        end
    endtask

    initial begin : stimulus
        int        waited;
        pv_vec_t   req;
        pv_vec_t   gnt;
        pv_vec_t   avail;
        cong_all_t cin;

        ivc_request_all   <= '0;
        ivc_granted_all   <= '0;
        ovc_available_all <= '1;  // idle router, nothing busy
        congestion_in_all <= '0;
        cong_errors    = 0;
        presel_errors  = 0;
        detect_errors  = 0;
        timeout_errors = 0;
        rng_state      = 32'h2395;

        // req, gnt, avail, congestion_in_all, expected report, expected preference
        rows[0] = '{20'h00000, 20'h00000, 20'hFFFFF, 15'h0000, 15'h0000, 4'h0};  // all idle
        rows[1] = '{20'h000F0, 20'h00000, 20'hFFFFF, 15'h32AF, 15'h0018, 4'hC};  // east load 12
        rows[2] = '{20'hFFFFF, 20'h00000, 20'h00000, 15'h4925, 15'h7FF8, 4'h0};  // load 24, ties
        rows[3] = '{20'h00010, 20'h00000, 20'hFFFFF, 15'h6E03, 15'h0000, 4'h3};  // east load 3
        rows[4] = '{20'h0001F, 20'h00000, 20'hFFEF0, 15'h6FB9, 15'h0008, 4'hF};  // east load 4
        rows[5] = '{20'h00070, 20'h00000, 20'h000FF, 15'h3B1A, 15'h24B0, 4'h3};  // east load 21
        rows[6] = '{20'h000F0, 20'h00000, 20'h300FF, 15'h0000, 15'h2278, 4'h0};  // east load 22
        rows[7] = '{20'h000F0, 20'h00030, 20'hFFFFF, 15'h32AF, 15'h0008, 4'hC};  // grants mask

        waited = 0;
        while (arst_n !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            timeout_errors++;
            $display("timeout: reset was never released");
        end
        @(negedge clk);
        check_cong(congestion_out_all, '0, "after reset");
        check_presel(port_pre_sel, '0, "after reset");
        check_detect(deadlock_detect, 1'b0, "after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            drive_inputs(rows[r].req, rows[r].gnt, rows[r].avail, rows[r].cin);
            wait_cycles(HOLD_CYCLES);
            @(negedge clk);
            check_cong(congestion_out_all, rows[r].exp_cong, $sformatf("row %0d", r));
            check_presel(port_pre_sel, rows[r].exp_presel, $sformatf("row %0d", r));
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            req       = rng_state[PV-1:0];
            rng_state = xorshift32(rng_state);
            gnt       = rng_state[PV-1:0];
            rng_state = xorshift32(rng_state);
            avail     = rng_state[PV-1:0];
            rng_state = xorshift32(rng_state);
            cin       = rng_state[NUM_PORTS*CONG_W-1:0];  // local field random too
            drive_inputs(req, gnt, avail, cin);
            wait_cycles(HOLD_CYCLES);
            @(negedge clk);
            check_cong(congestion_out_all, congestion_rule(req, gnt, avail),
                       $sformatf("random %0d", i));
            check_presel(port_pre_sel, preselect_rule(cin), $sformatf("random %0d", i));
        end

        // grants everywhere zero all stall counters
        drive_inputs('0, '1, '1, '0);
        wait_cycles(HOLD_CYCLES);
        @(negedge clk);
        check_detect(deadlock_detect, 1'b0, "counters cleared");

        drive_inputs(EAST_VC2, '0, '1, '0);  // VC 2 asks, never wins
        wait_detect(1'b1, 20, "VC 2 stalled");
        check_detect(deadlock_detect, 1'b1, "VC 2 stalled");

        drive_inputs(EAST_VC2, EAST_VC2, '1, '0);
        wait_detect(1'b0, 3, "VC 2 granted");
        check_detect(deadlock_detect, 1'b0, "VC 2 granted");
        // request still held, an uncleared counter would come back to 15
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_detect(deadlock_detect, 1'b0, $sformatf("VC 2 granted cycle %0d", i));
        end

        drive_inputs('1, '1, '1, '0);  // every request served each cycle
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            check_detect(deadlock_detect, 1'b0, $sformatf("granted cycle %0d", i));
        end

        $display("errors: congestion %0d, preselect %0d, detect %0d, timeout %0d",
                 cong_errors, presel_errors, detect_errors, timeout_errors);
        if (cong_errors + presel_errors + detect_errors + timeout_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;  // fifth rising edge ends reset
    end

endmodule

`default_nettype wire
